/* cc_pkg.sv */
// ------------------------------
// Core complex interconnect package
// Widths, offload request/response and data request/response structs
// ------------------------------

package cc_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  // Destination register tag
  localparam int unsigned IdWidth     = 5;
  // Port select, at most 8 accelerator ports
  localparam int unsigned AccSelWidth = 3;

  // ------------------------------
  // Offload channel
  // ------------------------------
  typedef struct packed {
    logic [AccSelWidth-1:0] sel;
    logic [IdWidth-1:0]     id;
    logic [31:0]            data_op;
    logic [DataWidth-1:0]   data_arga;
    logic [DataWidth-1:0]   data_argb;
  } acc_req_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic                 error;
  } acc_rsp_t;

  // ------------------------------
  // Data channel
  // ------------------------------
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic                 write;
    logic [StrbWidth-1:0] strb;
  } data_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 error;
  } data_rsp_t;

endpackage

/* offload_slice.sv */
// ------------------------------
// Two-entry valid/ready register slice
// Generic payload, registered ready towards the source
// ------------------------------

`timescale 1ns/1ps

module offload_slice #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Source side
  input  T     in_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  // Sink side
  output T     out_o,
  output logic out_valid_o,
  input  logic out_ready_i
);

  logic [1:0] count_q;
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic       push;
  logic       pop;
  T           mem_q [2];

  // Ready only depends on the fill level, so no combinational ready path
  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign out_o       = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // ------------------------------
  // Control state
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      count_q  <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i;
    end
  end

  // A stalled output keeps its valid and its payload
  assert property (@(posedge clk_i) disable iff (rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

/* offload_demux.sv */
// ------------------------------
// Offload request demux
// Steers one request stream to an accelerator port by its select field
// ------------------------------

`timescale 1ns/1ps

module offload_demux import cc_pkg::*; #(
  parameter int unsigned NumAccPorts = 4
) (
  // Request from the core side
  input  acc_req_t               req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  // Accelerator ports
  output acc_req_t               acc_q_o,
  output logic [NumAccPorts-1:0] acc_qvalid_o,
  input  logic [NumAccPorts-1:0] acc_qready_i
);

  logic sel_in_range;

  // Shared payload, only the valid is steered
  assign acc_q_o = req_i;

  assign sel_in_range = (32'(req_i.sel) < NumAccPorts);

  // One-hot valid from sel
  always_comb begin
    acc_qvalid_o = '0;
    for (int unsigned i = 0; i < NumAccPorts; i++) begin
      if (32'(req_i.sel) == i) begin
        acc_qvalid_o[i] = req_valid_i;
      end
    end
  end

  // Ready of the selected port, low for an unmapped select
  always_comb begin
    req_ready_o = 1'b0;
    for (int unsigned i = 0; i < NumAccPorts; i++) begin
      if (32'(req_i.sel) == i) begin
        req_ready_o = acc_qready_i[i];
      end
    end
  end

  // Requests to a non-existent port would stall forever
  always_comb begin
    if (req_valid_i) begin
      assert final (sel_in_range)
        else $error("offload select %0d beyond %0d ports", req_i.sel, NumAccPorts);
    end
  end

endmodule

/* offload_arbiter.sv */
// ------------------------------
// Round-robin merge of accelerator responses
// Holds the grant until the response is taken
// ------------------------------

`timescale 1ns/1ps

module offload_arbiter import cc_pkg::*; #(
  parameter int unsigned NumAccPorts = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Per-port responses
  input  acc_rsp_t [NumAccPorts-1:0]       rsp_i,
  input  logic     [NumAccPorts-1:0]       rsp_valid_i,
  output logic     [NumAccPorts-1:0]       rsp_ready_o,
  // Merged stream to the core
  output acc_rsp_t                         rsp_o,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i
);

  localparam int unsigned IdxWidth = (NumAccPorts > 1) ? $clog2(NumAccPorts) : 1;

  typedef logic [IdxWidth-1:0] idx_t;

  idx_t last_q;
  idx_t lock_idx_q;
  logic lock_q;
  idx_t gnt_idx;
  logic gnt_valid;
  logic xfer;

  // ------------------------------
  // Grant selection
  // ------------------------------
  always_comb begin
    int unsigned cand;
    cand      = 0;
    gnt_idx   = lock_idx_q;
    gnt_valid = 1'b0;
    if (lock_q) begin
      gnt_valid = rsp_valid_i[lock_idx_q];
    end else begin
      // Search starts one past the last granted port
      for (int unsigned i = 1; i <= NumAccPorts; i++) begin
        cand = (32'(last_q) + i) % NumAccPorts;
        if (!gnt_valid && rsp_valid_i[cand]) begin
          gnt_valid = 1'b1;
          gnt_idx   = idx_t'(cand);
        end
      end
    end
  end

  assign rsp_valid_o = gnt_valid;
  assign rsp_o       = rsp_i[gnt_idx];
  assign xfer        = gnt_valid & rsp_ready_i;

  always_comb begin
    rsp_ready_o          = '0;
    rsp_ready_o[gnt_idx] = xfer;
  end

  // Pointer moves on transfer and the lock holds a stalled grant
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      last_q     <= idx_t'(NumAccPorts - 1);
      lock_idx_q <= '0;
      lock_q     <= 1'b0;
    end else if (xfer) begin
      last_q <= gnt_idx;
      lock_q <= 1'b0;
    end else if (gnt_valid) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

  // A stalled grant keeps the same response on the output
  assert property (@(posedge clk_i) disable iff (rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

/* data_router.sv */
// ------------------------------
// Data request router between the TCDM window and SoC
// In-order response return through a FIFO of port selects
// ------------------------------

`timescale 1ns/1ps

module data_router import cc_pkg::*; #(
  parameter int unsigned TcdmAddrWidth = 12,
  parameter int unsigned DataRespDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [AddrWidth-1:0] tcdm_addr_base_i,
  // Core data port
  input  data_req_t            data_req_i,
  input  logic                 data_req_valid_i,
  output logic                 data_req_ready_o,
  output data_rsp_t            data_rsp_o,
  output logic                 data_rsp_valid_o,
  input  logic                 data_rsp_ready_i,
  // TCDM port
  output data_req_t            tcdm_req_o,
  output logic                 tcdm_req_valid_o,
  input  logic                 tcdm_req_ready_i,
  input  data_rsp_t            tcdm_rsp_i,
  input  logic                 tcdm_rsp_valid_i,
  output logic                 tcdm_rsp_ready_o,
  // SoC port
  output data_req_t            soc_req_o,
  output logic                 soc_req_valid_o,
  input  logic                 soc_req_ready_i,
  input  data_rsp_t            soc_rsp_i,
  input  logic                 soc_rsp_valid_i,
  output logic                 soc_rsp_ready_o
);

  localparam int unsigned PtrWidth = (DataRespDepth > 1) ? $clog2(DataRespDepth) : 1;
  localparam int unsigned CntWidth = $clog2(DataRespDepth + 1);

  logic [DataRespDepth-1:0] sel_q;
  logic [PtrWidth-1:0]      wr_ptr_q;
  logic [PtrWidth-1:0]      rd_ptr_q;
  logic [CntWidth-1:0]      count_q;
  logic                     fifo_full;
  logic                     fifo_empty;
  logic                     is_tcdm;
  logic                     head_tcdm;
  logic                     push;
  logic                     pop;

  // ------------------------------
  // Request path
  // ------------------------------
  // Naturally aligned window compared above the TCDM offset bits
  assign is_tcdm = (data_req_i.addr[AddrWidth-1:TcdmAddrWidth] ==
                    tcdm_addr_base_i[AddrWidth-1:TcdmAddrWidth]);

  assign tcdm_req_o       = data_req_i;
  assign soc_req_o        = data_req_i;
  assign tcdm_req_valid_o = data_req_valid_i & is_tcdm & ~fifo_full;
  assign soc_req_valid_o  = data_req_valid_i & ~is_tcdm & ~fifo_full;
  assign data_req_ready_o = ~fifo_full & (is_tcdm ? tcdm_req_ready_i : soc_req_ready_i);

  // ------------------------------
  // Response path
  // ------------------------------
  assign fifo_full  = (count_q == CntWidth'(DataRespDepth));
  assign fifo_empty = (count_q == '0);
  assign head_tcdm  = sel_q[rd_ptr_q];

  // Only the port at the head may answer
  assign data_rsp_o       = head_tcdm ? tcdm_rsp_i : soc_rsp_i;
  assign data_rsp_valid_o = ~fifo_empty & (head_tcdm ? tcdm_rsp_valid_i : soc_rsp_valid_i);
  assign tcdm_rsp_ready_o = ~fifo_empty & head_tcdm & data_rsp_ready_i;
  assign soc_rsp_ready_o  = ~fifo_empty & ~head_tcdm & data_rsp_ready_i;

  assign push = data_req_valid_i & data_req_ready_o;
  assign pop  = data_rsp_valid_o & data_rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(DataRespDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(DataRespDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // 1 marks an outstanding TCDM access
  always_ff @(posedge clk_i) begin
    if (push) begin
      sel_q[wr_ptr_q] <= is_tcdm;
    end
  end

  // A memory answers only while an access is outstanding
  assert property (@(posedge clk_i) disable iff (rst_ni)
    (tcdm_rsp_valid_i || soc_rsp_valid_i) |-> !fifo_empty);

endmodule

/* cc_interconnect.sv */
// ------------------------------
// Core complex interconnect top
// Offload request cut, demux, response slices, arbiter, data router
// ------------------------------

`timescale 1ns/1ps

module cc_interconnect import cc_pkg::*; #(
  parameter int unsigned NumAccPorts   = 4,
  parameter int unsigned TcdmAddrWidth = 12,
  parameter int unsigned DataRespDepth = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Offload port from the core
  input  acc_req_t                   offload_req_i,
  input  logic                       offload_req_valid_i,
  output logic                       offload_req_ready_o,
  output acc_rsp_t                   offload_rsp_o,
  output logic                       offload_rsp_valid_o,
  input  logic                       offload_rsp_ready_i,
  // Accelerator ports
  output acc_req_t                   acc_q_o,
  output logic     [NumAccPorts-1:0] acc_qvalid_o,
  input  logic     [NumAccPorts-1:0] acc_qready_i,
  input  acc_rsp_t [NumAccPorts-1:0] acc_p_i,
  input  logic     [NumAccPorts-1:0] acc_pvalid_i,
  output logic     [NumAccPorts-1:0] acc_pready_o,
  // Data ports
  input  logic [AddrWidth-1:0]       tcdm_addr_base_i,
  input  data_req_t                  data_req_i,
  input  logic                       data_req_valid_i,
  output logic                       data_req_ready_o,
  output data_rsp_t                  data_rsp_o,
  output logic                       data_rsp_valid_o,
  input  logic                       data_rsp_ready_i,
  output data_req_t                  tcdm_req_o,
  output logic                       tcdm_req_valid_o,
  input  logic                       tcdm_req_ready_i,
  input  data_rsp_t                  tcdm_rsp_i,
  input  logic                       tcdm_rsp_valid_i,
  output logic                       tcdm_rsp_ready_o,
  output data_req_t                  soc_req_o,
  output logic                       soc_req_valid_o,
  input  logic                       soc_req_ready_i,
  input  data_rsp_t                  soc_rsp_i,
  input  logic                       soc_rsp_valid_i,
  output logic                       soc_rsp_ready_o
);

  acc_req_t                   req_q;
  logic                       req_q_valid;
  logic                       req_q_ready;
  acc_rsp_t [NumAccPorts-1:0] rsp_q;
  logic     [NumAccPorts-1:0] rsp_q_valid;
  logic     [NumAccPorts-1:0] rsp_q_ready;

  // ------------------------------
  // Offload request path
  // ------------------------------
  offload_slice #(
    .T (acc_req_t)
  ) i_req_slice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_i        (offload_req_i),
    .in_valid_i  (offload_req_valid_i),
    .in_ready_o  (offload_req_ready_o),
    .out_o       (req_q),
    .out_valid_o (req_q_valid),
    .out_ready_i (req_q_ready)
  );

  offload_demux #(
    .NumAccPorts (NumAccPorts)
  ) i_demux (
    .req_i        (req_q),
    .req_valid_i  (req_q_valid),
    .req_ready_o  (req_q_ready),
    .acc_q_o      (acc_q_o),
    .acc_qvalid_o (acc_qvalid_o),
    .acc_qready_i (acc_qready_i)
  );

  // ------------------------------
  // Offload response path
  // ------------------------------
  // One slice per accelerator before the merge
  for (genvar i = 0; i < NumAccPorts; i++) begin : gen_rsp_slice
    offload_slice #(
      .T (acc_rsp_t)
    ) i_rsp_slice (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .in_i        (acc_p_i[i]),
      .in_valid_i  (acc_pvalid_i[i]),
      .in_ready_o  (acc_pready_o[i]),
      .out_o       (rsp_q[i]),
      .out_valid_o (rsp_q_valid[i]),
      .out_ready_i (rsp_q_ready[i])
    );
  end

  offload_arbiter #(
    .NumAccPorts (NumAccPorts)
  ) i_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rsp_i       (rsp_q),
    .rsp_valid_i (rsp_q_valid),
    .rsp_ready_o (rsp_q_ready),
    .rsp_o       (offload_rsp_o),
    .rsp_valid_o (offload_rsp_valid_o),
    .rsp_ready_i (offload_rsp_ready_i)
  );

  // ------------------------------
  // Data path
  // ------------------------------
  data_router #(
    .TcdmAddrWidth (TcdmAddrWidth),
    .DataRespDepth (DataRespDepth)
  ) i_data_router (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tcdm_addr_base_i (tcdm_addr_base_i),
    .data_req_i       (data_req_i),
    .data_req_valid_i (data_req_valid_i),
    .data_req_ready_o (data_req_ready_o),
    .data_rsp_o       (data_rsp_o),
    .data_rsp_valid_o (data_rsp_valid_o),
    .data_rsp_ready_i (data_rsp_ready_i),
    .tcdm_req_o       (tcdm_req_o),
    .tcdm_req_valid_o (tcdm_req_valid_o),
    .tcdm_req_ready_i (tcdm_req_ready_i),
    .tcdm_rsp_i       (tcdm_rsp_i),
    .tcdm_rsp_valid_i (tcdm_rsp_valid_i),
    .tcdm_rsp_ready_o (tcdm_rsp_ready_o),
    .soc_req_o        (soc_req_o),
    .soc_req_valid_o  (soc_req_valid_o),
    .soc_req_ready_i  (soc_req_ready_i),
    .soc_rsp_i        (soc_rsp_i),
    .soc_rsp_valid_i  (soc_rsp_valid_i),
    .soc_rsp_ready_o  (soc_rsp_ready_o)
  );

endmodule

/* tb_cc_interconnect.sv */
// ------------------------------
// Testbench for the core complex interconnect
// Data-file stimulus, accelerator and memory models, checks
// ------------------------------

`timescale 1ns/1ps

module tb_cc_interconnect import cc_pkg::*; ();

  localparam int unsigned NumPorts    = 4;
  localparam int          Timeout     = 2000;
  localparam int          TcdmLatency = 1;
  localparam int          SocLatency  = 5;
  localparam logic [31:0] Seed        = 32'h1f63_d190;
  localparam logic [31:0] TcdmBase    = 32'h1000_0000;
  localparam string       DataFile    = "cc_testdata.txt";

  logic                    clk_i;
  logic                    rst_ni;
  acc_req_t                off_req;
  logic                    off_req_valid;
  logic                    off_req_ready;
  acc_rsp_t                off_rsp;
  logic                    off_rsp_valid;
  logic                    off_rsp_ready;
  acc_req_t                acc_q;
  logic     [NumPorts-1:0] acc_qvalid;
  logic     [NumPorts-1:0] acc_qready;
  acc_rsp_t [NumPorts-1:0] acc_p;
  logic     [NumPorts-1:0] acc_pvalid;
  logic     [NumPorts-1:0] acc_pready;
  logic     [31:0]         tcdm_base;
  data_req_t               data_req;
  logic                    data_req_valid;
  logic                    data_req_ready;
  data_rsp_t               data_rsp;
  logic                    data_rsp_valid;
  logic                    data_rsp_ready;
  data_req_t               tcdm_req;
  logic                    tcdm_req_valid;
  logic                    tcdm_req_ready;
  data_rsp_t               tcdm_rsp;
  logic                    tcdm_rsp_valid;
  logic                    tcdm_rsp_ready;
  data_req_t               soc_req;
  logic                    soc_req_valid;
  logic                    soc_req_ready;
  data_rsp_t               soc_rsp;
  logic                    soc_rsp_valid;
  logic                    soc_rsp_ready;

  int err_value;
  int err_other;

  // Stimulus and expected values from the data file
  acc_req_t  off_stim [$];
  acc_req_t  exp_req [NumPorts][$];
  acc_rsp_t  exp_rsp [NumPorts][$];
  data_req_t data_stim [$];
  int        data_port [$];
  data_rsp_t exp_data [$];

  // Model state, index 0 is TCDM and 1 is SoC for the memories
  acc_rsp_t  acc_pending [NumPorts][$];
  data_rsp_t mem_rsp [2][$];
  int        mem_due [2][$];
  int        data_acc;

  cc_interconnect dut_i (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .offload_req_i (off_req), .offload_req_valid_i (off_req_valid),
    .offload_req_ready_o (off_req_ready), .offload_rsp_o (off_rsp),
    .offload_rsp_valid_o (off_rsp_valid), .offload_rsp_ready_i (off_rsp_ready),
    .acc_q_o (acc_q), .acc_qvalid_o (acc_qvalid), .acc_qready_i (acc_qready),
    .acc_p_i (acc_p), .acc_pvalid_i (acc_pvalid), .acc_pready_o (acc_pready),
    .tcdm_addr_base_i (tcdm_base),
    .data_req_i (data_req), .data_req_valid_i (data_req_valid),
    .data_req_ready_o (data_req_ready), .data_rsp_o (data_rsp),
    .data_rsp_valid_o (data_rsp_valid), .data_rsp_ready_i (data_rsp_ready),
    .tcdm_req_o (tcdm_req), .tcdm_req_valid_o (tcdm_req_valid),
    .tcdm_req_ready_i (tcdm_req_ready), .tcdm_rsp_i (tcdm_rsp),
    .tcdm_rsp_valid_i (tcdm_rsp_valid), .tcdm_rsp_ready_o (tcdm_rsp_ready),
    .soc_req_o (soc_req), .soc_req_valid_o (soc_req_valid),
    .soc_req_ready_i (soc_req_ready), .soc_rsp_i (soc_rsp),
    .soc_rsp_valid_i (soc_rsp_valid), .soc_rsp_ready_o (soc_rsp_ready)
  );

  always #2 clk_i = ~clk_i;

  task automatic drive_idle();
    off_req        = '0;
    off_req_valid  = 1'b0;
    off_rsp_ready  = 1'b0;
    acc_qready     = '0;
    acc_p          = '0;
    acc_pvalid     = '0;
    tcdm_base      = TcdmBase;
    data_req       = '0;
    data_req_valid = 1'b0;
    data_rsp_ready = 1'b0;
    tcdm_req_ready = 1'b0;
    tcdm_rsp       = '0;
    tcdm_rsp_valid = 1'b0;
    soc_req_ready  = 1'b0;
    soc_rsp        = '0;
    soc_rsp_valid  = 1'b0;
  endtask

  // ------------------------------
  // Data file reader
  // ------------------------------
  task automatic read_testdata();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f0, f1, f2, f3, f4;
    acc_req_t    req;
    acc_rsp_t    rsp;
    data_req_t   dreq;
    data_rsp_t   drsp;
    fd = $fopen(DataFile, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", DataFile);
      err_other++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 2 && line[0] == "O") begin
        n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h", f0, f1, f2, f3, f4);
        req.sel       = f0[AccSelWidth-1:0];
        req.id        = f1[IdWidth-1:0];
        req.data_op   = f2;
        req.data_arga = f3;
        req.data_argb = f4;
        // Accelerator rule: id unchanged, data is the operand sum
        rsp.id    = req.id;
        rsp.data  = f3 + f4;
        rsp.error = 1'b0;
        off_stim.push_back(req);
        exp_req[int'(f0)].push_back(req);
        exp_rsp[int'(f0)].push_back(rsp);
      end else if (n > 2 && line[0] == "D") begin
        n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3);
        dreq.addr  = f0;
        dreq.write = f1[0];
        dreq.wdata = f2;
        dreq.strb  = f1[0] ? 4'hf : 4'h0;
        // Memory rule: reads return address plus 1 (TCDM) or 2 (SoC)
        drsp.rdata = f1[0] ? 32'h0 : f0 + ((f3 == 0) ? 32'd1 : 32'd2);
        drsp.error = 1'b0;
        data_stim.push_back(dreq);
        data_port.push_back(int'(f3));
        exp_data.push_back(drsp);
      end
    end
    $fclose(fd);
  endtask

  task automatic check_reset_outputs();
    assert ({acc_qvalid, off_rsp_valid, tcdm_req_valid, soc_req_valid, data_rsp_valid} == '0)
      else begin
        $display("Fail reset_outputs: expected %h actual %h", 8'h0,
                 {acc_qvalid, off_rsp_valid, tcdm_req_valid, soc_req_valid, data_rsp_valid});
        err_value++;
      end
  endtask

  // ------------------------------
  // Offload traffic, random readies
  // ------------------------------
  task automatic run_offload();
    int       sent;
    int       got;
    int       cycles;
    int       hit;
    acc_rsp_t rsp;
    sent   = 0;
    got    = 0;
    cycles = 0;
    while ((got < off_stim.size()) && (cycles < Timeout)) begin
      @(posedge clk_i);
      #1;
      off_req_valid = (sent < off_stim.size());
      if (off_req_valid) begin
        off_req = off_stim[sent];
      end
      acc_qready    = NumPorts'($urandom);
      off_rsp_ready = ($urandom % 3) != 0;
      for (int p = 0; p < NumPorts; p++) begin
        acc_pvalid[p] = (acc_pending[p].size() > 0);
        if (acc_pvalid[p]) begin
          acc_p[p] = acc_pending[p][0];
        end
      end
      @(negedge clk_i);
      if (off_req_valid && off_req_ready) begin
        sent++;
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (acc_pvalid[p] && acc_pready[p]) begin
          void'(acc_pending[p].pop_front());
        end
        if (acc_qvalid[p] && acc_qready[p]) begin
          assert (exp_req[p].size() > 0)
            else begin
              $display("Unexpected offload request on port %0d", p);
              err_other++;
            end
          if (exp_req[p].size() > 0) begin
            assert (acc_q == exp_req[p][0])
              else begin
                $display("Fail offload_req port %0d: expected %h actual %h", p,
                         exp_req[p][0], acc_q);
                err_value++;
              end
            void'(exp_req[p].pop_front());
          end
          rsp.id    = acc_q.id;
          rsp.data  = acc_q.data_arga + acc_q.data_argb;
          rsp.error = 1'b0;
          acc_pending[p].push_back(rsp);
        end
      end
      if (off_rsp_valid && off_rsp_ready) begin
        hit = -1;
        for (int p = 0; p < NumPorts; p++) begin
          if (hit < 0 && exp_rsp[p].size() > 0 && exp_rsp[p][0].id == off_rsp.id) begin
            hit = p;
          end
        end
        assert (hit >= 0)
          else begin
            $display("Offload response with id %0d that no port has pending", off_rsp.id);
            err_other++;
          end
        if (hit >= 0) begin
          assert (off_rsp == exp_rsp[hit][0])
            else begin
              $display("Fail offload_rsp port %0d: expected %h actual %h", hit,
                       exp_rsp[hit][0], off_rsp);
              err_value++;
            end
          void'(exp_rsp[hit].pop_front());
        end
        got++;
      end
      cycles++;
    end
    assert (cycles < Timeout)
      else begin
        $display("Timeout: %0d of %0d offload responses returned", got, off_stim.size());
        err_other++;
      end
  endtask

  // ------------------------------
  // Round-robin order
  // ------------------------------
  task automatic check_round_robin();
    int sent [NumPorts];
    int seen [NumPorts];
    int filled;
    int got;
    int prev;
    int port;
    int cycles;
    for (int p = 0; p < NumPorts; p++) begin
      sent[p] = 0;
      seen[p] = 0;
    end
    filled = 0;
    cycles = 0;
    // Two tagged responses per port while the core stalls
    while ((filled < NumPorts) && (cycles < Timeout)) begin
      @(posedge clk_i);
      #1;
      off_req_valid = 1'b0;
      off_rsp_ready = 1'b0;
      for (int p = 0; p < NumPorts; p++) begin
        acc_pvalid[p] = (sent[p] < 2);
        acc_p[p]      = '{id: IdWidth'(p), data: {16'(p), 16'(sent[p])}, error: 1'b0};
      end
      @(negedge clk_i);
      filled = 0;
      for (int p = 0; p < NumPorts; p++) begin
        if (acc_pvalid[p] && acc_pready[p]) begin
          sent[p]++;
        end
        if (sent[p] == 2) begin
          filled++;
        end
      end
      cycles++;
    end
    got  = 0;
    prev = -1;
    while ((got < 2 * NumPorts) && (cycles < Timeout)) begin
      @(posedge clk_i);
      #1;
      acc_pvalid    = '0;
      off_rsp_ready = 1'b1;
      @(negedge clk_i);
      if (off_rsp_valid) begin
        port = int'(off_rsp.data[31:16]) % NumPorts;
        if (prev >= 0) begin
          assert (port == (prev + 1) % NumPorts)
            else begin
              $display("Fail round_robin: expected %0d actual %0d", (prev + 1) % NumPorts, port);
              err_value++;
            end
        end
        assert (int'(off_rsp.data[15:0]) == seen[port])
          else begin
            $display("Fail round_robin_order port %0d: expected %0d actual %0d", port,
                     seen[port], off_rsp.data[15:0]);
            err_value++;
          end
        seen[port]++;
        prev = port;
        got++;
      end
      cycles++;
    end
    assert (cycles < Timeout)
      else begin
        $display("Timeout: round-robin phase saw %0d of %0d responses", got, 2 * NumPorts);
        err_other++;
      end
  endtask

  // ------------------------------
  // Data path, SoC slower than TCDM
  // ------------------------------
  task automatic accept_mem_req(input int port, input data_req_t req, input int now);
    data_rsp_t rsp;
    assert (port == data_port[data_acc])
      else begin
        $display("Fail data_port req %0d: expected %0d actual %0d", data_acc,
                 data_port[data_acc], port);
        err_value++;
      end
    assert (req == data_stim[data_acc])
      else begin
        $display("Fail data_req %0d: expected %h actual %h", data_acc, data_stim[data_acc], req);
        err_value++;
      end
    rsp.rdata = req.write ? 32'h0 : req.addr + ((port == 0) ? 32'd1 : 32'd2);
    rsp.error = 1'b0;
    mem_rsp[port].push_back(rsp);
    mem_due[port].push_back(now + ((port == 0) ? TcdmLatency : SocLatency));
    data_acc++;
  endtask

  task automatic run_data();
    int sent;
    int got;
    int cycles;
    sent     = 0;
    got      = 0;
    cycles   = 0;
    data_acc = 0;
    while ((got < data_stim.size()) && (cycles < Timeout)) begin
      @(posedge clk_i);
      #1;
      data_req_valid = (sent < data_stim.size());
      if (data_req_valid) begin
        data_req = data_stim[sent];
      end
      tcdm_req_ready = ($urandom % 4) != 0;
      soc_req_ready  = ($urandom % 4) != 0;
      data_rsp_ready = ($urandom % 4) != 0;
      tcdm_rsp_valid = (mem_rsp[0].size() > 0) && (mem_due[0][0] <= cycles);
      soc_rsp_valid  = (mem_rsp[1].size() > 0) && (mem_due[1][0] <= cycles);
      if (mem_rsp[0].size() > 0) begin
        tcdm_rsp = mem_rsp[0][0];
      end
      if (mem_rsp[1].size() > 0) begin
        soc_rsp = mem_rsp[1][0];
      end
      @(negedge clk_i);
      if (tcdm_req_valid && tcdm_req_ready) begin
        accept_mem_req(0, tcdm_req, cycles);
      end
      if (soc_req_valid && soc_req_ready) begin
        accept_mem_req(1, soc_req, cycles);
      end
      if (data_req_valid && data_req_ready) begin
        sent++;
      end
      if (tcdm_rsp_valid && tcdm_rsp_ready) begin
        void'(mem_rsp[0].pop_front());
        void'(mem_due[0].pop_front());
      end
      if (soc_rsp_valid && soc_rsp_ready) begin
        void'(mem_rsp[1].pop_front());
        void'(mem_due[1].pop_front());
      end
      if (data_rsp_valid && data_rsp_ready) begin
        assert (data_rsp == exp_data[got])
          else begin
            $display("Fail data_rsp %0d: expected %h actual %h", got, exp_data[got], data_rsp);
            err_value++;
          end
        got++;
      end
      cycles++;
    end
    assert (cycles < Timeout)
      else begin
        $display("Timeout: %0d of %0d data responses returned", got, data_stim.size());
        err_other++;
      end
  endtask

  initial begin
    void'($urandom(Seed));
    err_value = 0;
    err_other = 0;
    clk_i     = 1'b0;
    rst_ni    = 1'b1;
    drive_idle();
    read_testdata();
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b0;
    @(negedge clk_i);
    check_reset_outputs();
    run_offload();
    check_round_robin();
    run_data();
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* cc_testdata.txt */
# Offload rows: O sel id op arga argb (hex)
# Data rows: D addr write wdata port (hex, port 0 is TCDM, 1 is SoC)
O 0 01 00000033 00000010 00000020
O 1 02 0000003b 00000100 00000200
O 2 03 02000033 12345678 11111111
O 3 04 0000702b ffffffff 00000001
O 0 05 00001033 00000005 00000007
O 0 06 00002033 80000000 80000000
O 1 07 0000303b 0000abcd 00001234
O 2 08 02004033 00000000 00000000
O 3 09 0000502b 7fffffff 00000001
O 1 0a 0000603b deadbeef 00000001
O 2 0b 02007033 00010000 000f0000
O 3 0c 0000002b 00000003 00000004
O 0 0d 00001033 cafef00d 00000100
O 1 0e 0000203b 00000042 00000042
O 2 0f 02003033 fffffff0 00000010
O 3 10 0000402b 13579bdf 02468ace
D 10000000 0 00000000 0
D 80000100 0 00000000 1
D 10000004 1 cafe0001 0
D 10000ffc 0 00000000 0
D 10001000 0 00000000 1
D 00000040 1 0badf00d 1
D 10000010 0 00000000 0
D 10000020 0 00000000 0
D 10010000 0 00000000 1
D 10000800 1 deadbeef 0
D 90000000 0 00000000 1
D 10000100 0 00000000 0

/* tb.f */
cc_pkg.sv
offload_slice.sv
offload_demux.sv
offload_arbiter.sv
data_router.sv
cc_interconnect.sv
tb_cc_interconnect.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cc_interconnect -f tb.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
else
  exit 1
fi
